// File: Bender.yml
package:
  name: cnn

sources:
  - common/cnn_pkg.sv
  - common/cnn_if.sv
  - src/host_port.sv
  - src/input_store.sv
  - conv/conv_layer.sv
  - pool/pool_banks.sv
  - pool/maxpool_layer.sv
  - src/cnn.sv
  - target: test
    files:
      - tb/cnn_checker.sv
      - tb/tb_cnn.sv

// File: common/cnn_if.sv
`timescale 1ns/1ps

// host writes into the pixel, weight and bias stores
interface store_write_if;
	cnn_pkg::byte_t addr;
	cnn_pkg::byte_t data;
	logic pixel_we;
	logic weight_we;
	logic bias_we;
	// upper byte of the bias
	logic bias_hi;

	modport host (output addr, data, pixel_we, weight_we, bias_we, bias_hi);
	modport store (input addr, data, pixel_we, weight_we, bias_we, bias_hi);
endinterface

// one convolution output per pulse
interface conv_save_if;
	logic save_enable;
	cnn_pkg::coord_t row;
	cnn_pkg::coord_t col;
	cnn_pkg::feature_t data;

	modport conv (output save_enable, row, col, data);
	modport bank (input save_enable, row, col, data);
endinterface

// one address returns a whole 2x2 window
interface bank_read_if;
	logic read_signal;
	cnn_pkg::bank_addr_t addr;
	cnn_pkg::feature_t even_even;
	cnn_pkg::feature_t even_odd;
	cnn_pkg::feature_t odd_even;
	cnn_pkg::feature_t odd_odd;

	modport pool (
		output read_signal, addr,
		input  even_even, even_odd, odd_even, odd_odd
	);
	modport bank (
		input  read_signal, addr,
		output even_even, even_odd, odd_even, odd_odd
	);
endinterface

// File: common/cnn_pkg.sv
package cnn_pkg;

	////////////////////
	// widths
	typedef logic [31:0] bus_word_t;
	typedef logic [7:0] byte_t;
	typedef logic [7:0] pixel_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] bias_t;
	typedef logic signed [23:0] acc_t;
	typedef logic [15:0] feature_t;
	typedef logic [2:0] coord_t;
	typedef logic [3:0] bank_addr_t;
	// pixel index in bits 9:4, kernel tap in bits 3:0
	typedef logic [9:0] store_addr_t;

	////////////////////
	// image geometry
	localparam int IMG_SIZE = 8;
	localparam int KERNEL_SIZE = 3;
	localparam int CONV_SIZE = 6;
	localparam int POOL_SIZE = 3;
	localparam int NUM_RESULTS = 9;
	localparam int FEATURE_MAX = 65535;

	////////////////////
	// address map
	// the low byte of an address indexes its region
	localparam bus_word_t REGION_MASK = 32'hffff_ff00;
	localparam bus_word_t PIXEL_BASE = 32'h1000_0000;
	localparam bus_word_t WEIGHT_BASE = 32'h2000_0000;
	localparam bus_word_t BIAS_BASE = 32'h3000_0000;
	localparam bus_word_t IMAGE_SET_ADDR = 32'h4000_0000;
	localparam bus_word_t INTERRUPT_ADDR = 32'h5000_0000;
	localparam bus_word_t RESULT_BASE = 32'hd000_0000;

	// convolution sequencer
	typedef enum logic [1:0] {IDLE, ACCUM, BIAS, SAVE} conv_state_t;

endpackage

// File: conv/conv_layer.sv
`timescale 1ns/1ps

module conv_layer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	output cnn_pkg::store_addr_t read_addr,
	input  cnn_pkg::pixel_t      pixel,
	input  cnn_pkg::weight_t     weight,
	input  cnn_pkg::bias_t       bias,
	conv_save_if.conv            save,
	output logic                 conv_done
);

	cnn_pkg::conv_state_t state;
	cnn_pkg::coord_t out_row;
	cnn_pkg::coord_t out_col;
	cnn_pkg::coord_t k_row;
	cnn_pkg::coord_t k_col;
	cnn_pkg::acc_t acc;
	cnn_pkg::acc_t product;
	logic [3:0] tap;
	logic first_tap;

	////////////////////
	// store addressing
	assign tap = 4'(k_row * cnn_pkg::KERNEL_SIZE + k_col);
	assign first_tap = (k_row == '0) && (k_col == '0);
	assign read_addr = {
		cnn_pkg::coord_t'(out_row + k_row),
		cnn_pkg::coord_t'(out_col + k_col),
		tap
	};

	// pixel and weight belong to the tap issued last cycle
	assign product = $signed({1'b0, pixel}) * weight;

	////////////////////
	// sequencer
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= cnn_pkg::IDLE;
			out_row <= '0;
			out_col <= '0;
			k_row <= '0;
			k_col <= '0;
			conv_done <= 1'b0;
		end
		else
		begin
			conv_done <= 1'b0;
			case (state)
				cnn_pkg::IDLE:
				begin
					if (start)
						state <= cnn_pkg::ACCUM;
				end
				cnn_pkg::ACCUM:
				begin
					if (k_col == cnn_pkg::KERNEL_SIZE - 1)
					begin
						k_col <= '0;
						if (k_row == cnn_pkg::KERNEL_SIZE - 1)
						begin
							k_row <= '0;
							state <= cnn_pkg::BIAS;
						end
						else
							k_row <= k_row + 1'b1;
					end
					else
						k_col <= k_col + 1'b1;
				end
				cnn_pkg::BIAS:
					state <= cnn_pkg::SAVE;
				cnn_pkg::SAVE:
				begin
					state <= cnn_pkg::ACCUM;
					if (out_col == cnn_pkg::CONV_SIZE - 1)
					begin
						out_col <= '0;
						if (out_row == cnn_pkg::CONV_SIZE - 1)
						begin
							out_row <= '0;
							state <= cnn_pkg::IDLE;
							conv_done <= 1'b1;
						end
						else
							out_row <= out_row + 1'b1;
					end
					else
						out_col <= out_col + 1'b1;
				end
				default:
					state <= cnn_pkg::IDLE;
			endcase
		end
	end

	// last product arrives together with the bias
	always_ff @(posedge clk)
	begin
		case (state)
			cnn_pkg::ACCUM:
				acc <= first_tap ? '0 : acc + product;
			cnn_pkg::BIAS:
				acc <= acc + product + bias;
			default:
				acc <= acc;
		endcase
	end

	////////////////////
	// ReLU and clip
	assign save.save_enable = state == cnn_pkg::SAVE;
	assign save.row = out_row;
	assign save.col = out_col;

	always_comb
	begin
		if (acc < 0)
			save.data = '0;
		else if (acc > cnn_pkg::FEATURE_MAX)
			save.data = cnn_pkg::feature_t'(cnn_pkg::FEATURE_MAX);
		else
			save.data = acc[15:0];
	end

endmodule

// File: pool/maxpool_layer.sv
`timescale 1ns/1ps

module maxpool_layer (
	input  logic                clk,
	input  logic                rst,
	input  logic                conv_done,
	bank_read_if.pool           read,
	output logic                result_we,
	output cnn_pkg::bank_addr_t result_addr,
	output cnn_pkg::feature_t   result_data,
	output logic                pool_done
);

	logic busy;
	// low for the read, high for the write
	logic phase;
	cnn_pkg::bank_addr_t idx;
	cnn_pkg::feature_t top_max;
	cnn_pkg::feature_t bottom_max;

	assign read.read_signal = busy && !phase;
	assign read.addr = idx;
	assign result_we = busy && phase;
	assign result_addr = idx;

	////////////////////
	// 2x2 maximum
	assign top_max = (read.even_even > read.even_odd) ? read.even_even : read.even_odd;
	assign bottom_max = (read.odd_even > read.odd_odd) ? read.odd_even : read.odd_odd;
	assign result_data = (top_max > bottom_max) ? top_max : bottom_max;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			phase <= 1'b0;
			idx <= '0;
			pool_done <= 1'b0;
		end
		else
		begin
			pool_done <= 1'b0;
			if (!busy)
			begin
				busy <= conv_done;
				phase <= 1'b0;
				idx <= '0;
			end
			else if (!phase)
				phase <= 1'b1;
			else
			begin
				phase <= 1'b0;
				if (idx == cnn_pkg::NUM_RESULTS - 1)
				begin
					busy <= 1'b0;
					idx <= '0;
					pool_done <= 1'b1;
				end
				else
					idx <= idx + 1'b1;
			end
		end
	end

endmodule

// File: pool/pool_banks.sv
`timescale 1ns/1ps

module pool_banks (
	input  logic      clk,
	input  logic      rst,
	conv_save_if.bank save,
	bank_read_if.bank read
);

	// index is {row parity, col parity}
	cnn_pkg::feature_t bank [4][cnn_pkg::NUM_RESULTS];
	logic [1:0] save_bank;
	cnn_pkg::bank_addr_t save_addr;

	assign save_bank = {save.row[0], save.col[0]};
	assign save_addr = cnn_pkg::bank_addr_t'((save.row >> 1) * cnn_pkg::POOL_SIZE
		+ (save.col >> 1));

	always_ff @(posedge clk)
	begin
		if (save.save_enable)
			bank[save_bank][save_addr] <= save.data;
	end

	// whole 2x2 window one cycle after the request
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			read.even_even <= '0;
			read.even_odd <= '0;
			read.odd_even <= '0;
			read.odd_odd <= '0;
		end
		else if (read.read_signal)
		begin
			read.even_even <= bank[0][read.addr];
			read.even_odd <= bank[1][read.addr];
			read.odd_even <= bank[2][read.addr];
			read.odd_odd <= bank[3][read.addr];
		end
	end

endmodule

// File: src/cnn.sv
`timescale 1ns/1ps

module cnn (
	input  logic               clk,
	input  logic               rst,
	input  cnn_pkg::bus_word_t araddr,
	input  logic               arvalid,
	input  cnn_pkg::bus_word_t awaddr,
	input  logic               awvalid,
	input  cnn_pkg::bus_word_t wdata,
	input  logic               wvalid,
	output cnn_pkg::bus_word_t rdata,
	output logic               interrupt_signal
);

	logic start;
	logic conv_done;
	logic pool_done;
	logic result_we;
	cnn_pkg::bank_addr_t result_addr;
	cnn_pkg::feature_t result_data;

	cnn_pkg::store_addr_t store_read_addr;
	cnn_pkg::pixel_t store_pixel;
	cnn_pkg::weight_t store_weight;
	cnn_pkg::bias_t store_bias;

	store_write_if store_bus ();
	conv_save_if save_bus ();
	bank_read_if read_bus ();

	////////////////////
	// bus side
	host_port host_port_i (
		.clk              (clk),
		.rst              (rst),
		.araddr           (araddr),
		.arvalid          (arvalid),
		.awaddr           (awaddr),
		.awvalid          (awvalid),
		.wdata            (wdata),
		.wvalid           (wvalid),
		.rdata            (rdata),
		.interrupt_signal (interrupt_signal),
		.store            (store_bus.host),
		.start            (start),
		.result_we        (result_we),
		.result_addr      (result_addr),
		.result_data      (result_data),
		.pool_done        (pool_done)
	);

	input_store input_store_i (
		.clk       (clk),
		.store     (store_bus.store),
		.read_addr (store_read_addr),
		.pixel     (store_pixel),
		.weight    (store_weight),
		.bias      (store_bias)
	);

	////////////////////
	// datapath
	conv_layer conv_layer_i (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.read_addr (store_read_addr),
		.pixel     (store_pixel),
		.weight    (store_weight),
		.bias      (store_bias),
		.save      (save_bus.conv),
		.conv_done (conv_done)
	);

	pool_banks pool_banks_i (
		.clk  (clk),
		.rst  (rst),
		.save (save_bus.bank),
		.read (read_bus.bank)
	);

	maxpool_layer maxpool_layer_i (
		.clk         (clk),
		.rst         (rst),
		.conv_done   (conv_done),
		.read        (read_bus.pool),
		.result_we   (result_we),
		.result_addr (result_addr),
		.result_data (result_data),
		.pool_done   (pool_done)
	);

endmodule

// File: src/host_port.sv
`timescale 1ns/1ps

module host_port (
	input  logic                clk,
	input  logic                rst,
	input  cnn_pkg::bus_word_t  araddr,
	input  logic                arvalid,
	input  cnn_pkg::bus_word_t  awaddr,
	input  logic                awvalid,
	input  cnn_pkg::bus_word_t  wdata,
	input  logic                wvalid,
	output cnn_pkg::bus_word_t  rdata,
	output logic                interrupt_signal,
	store_write_if.host         store,
	output logic                start,
	input  logic                result_we,
	input  cnn_pkg::bank_addr_t result_addr,
	input  cnn_pkg::feature_t   result_data,
	input  logic                pool_done
);

	logic bus_write;
	logic pixel_hit;
	logic weight_hit;
	logic bias_hit;
	logic result_hit;
	cnn_pkg::feature_t result_mem [cnn_pkg::NUM_RESULTS];

	// address and data arrive together
	assign bus_write = awvalid && wvalid;
	assign pixel_hit = (awaddr & cnn_pkg::REGION_MASK) == cnn_pkg::PIXEL_BASE;
	assign weight_hit = (awaddr & cnn_pkg::REGION_MASK) == cnn_pkg::WEIGHT_BASE;
	assign bias_hit = (awaddr & cnn_pkg::REGION_MASK) == cnn_pkg::BIAS_BASE;

	////////////////////
	// write decode
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			store.pixel_we <= 1'b0;
			store.weight_we <= 1'b0;
			store.bias_we <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			store.pixel_we <= bus_write && pixel_hit;
			store.weight_we <= bus_write && weight_hit;
			store.bias_we <= bus_write && bias_hit;
			start <= bus_write && (awaddr == cnn_pkg::IMAGE_SET_ADDR);
		end
	end

	// index and byte of the current write
	always_ff @(posedge clk)
	begin
		store.addr <= awaddr[7:0];
		store.data <= wdata[7:0];
		store.bias_hi <= awaddr[0];
	end

	// set at the end of a run, cleared by a zero write
	always_ff @(posedge clk)
	begin
		if (rst)
			interrupt_signal <= 1'b0;
		else if (pool_done)
			interrupt_signal <= 1'b1;
		else if (bus_write && (awaddr == cnn_pkg::INTERRUPT_ADDR) && (wdata == '0))
			interrupt_signal <= 1'b0;
	end

	////////////////////
	// result memory
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < cnn_pkg::NUM_RESULTS; i++)
			begin
				result_mem[i] <= '0;
			end
		end
		else if (result_we)
		begin
			result_mem[result_addr] <= result_data;
		end
	end

	assign result_hit = arvalid
		&& ((araddr & cnn_pkg::REGION_MASK) == cnn_pkg::RESULT_BASE)
		&& (araddr[7:0] < cnn_pkg::NUM_RESULTS);

	// anything outside the result region reads as zero
	always_ff @(posedge clk)
	begin
		if (rst)
			rdata <= '0;
		else if (result_hit)
			rdata <= cnn_pkg::bus_word_t'(result_mem[araddr[3:0]]);
		else
			rdata <= '0;
	end

endmodule

// File: src/input_store.sv
`timescale 1ns/1ps

module input_store (
	input  logic                 clk,
	store_write_if.store         store,
	input  cnn_pkg::store_addr_t read_addr,
	output cnn_pkg::pixel_t      pixel,
	output cnn_pkg::weight_t     weight,
	output cnn_pkg::bias_t       bias
);

	cnn_pkg::pixel_t pixel_mem [cnn_pkg::IMG_SIZE * cnn_pkg::IMG_SIZE];
	cnn_pkg::weight_t weight_mem [cnn_pkg::KERNEL_SIZE * cnn_pkg::KERNEL_SIZE];

	////////////////////
	// host writes
	always_ff @(posedge clk)
	begin
		// pixel index is row * 8 + col
		if (store.pixel_we)
			pixel_mem[store.addr[5:0]] <= store.data;
		if (store.weight_we && (store.addr < cnn_pkg::KERNEL_SIZE * cnn_pkg::KERNEL_SIZE))
			weight_mem[store.addr[3:0]] <= cnn_pkg::weight_t'(store.data);
		if (store.bias_we)
		begin
			if (store.bias_hi)
				bias[15:8] <= store.data;
			else
				bias[7:0] <= store.data;
		end
	end

	////////////////////
	// layer reads
	// one cycle behind the address
	always_ff @(posedge clk)
	begin
		pixel <= pixel_mem[read_addr[9:4]];
		weight <= weight_mem[read_addr[3:0]];
	end

endmodule

// File: tb.f
common/cnn_pkg.sv
common/cnn_if.sv
src/host_port.sv
src/input_store.sv
conv/conv_layer.sv
pool/pool_banks.sv
pool/maxpool_layer.sv
src/cnn.sv
tb/cnn_checker.sv
tb/tb_cnn.sv

// File: tb/cnn_cases.txt
// per test: name in ascii and pixel load flag, 64 pixels row by row,
// 9 weights row-major then the 16-bit bias, then the 9 pooled results
// mix_sign: pixel c*c + 10*r, mixed-sign kernel, bias -100
6d69785f7369676e 1
00 01 04 09 10 19 24 31 0a 0b 0e 13 1a 23 2e 3b 14 15 18 1d 24 2d 38 45 1e 1f 22 27 2e 37 42 4f
28 29 2c 31 38 41 4c 59 32 33 36 3b 42 4b 56 63 3c 3d 40 45 4c 55 60 6d 46 47 4a 4f 56 5f 6a 77
01 00 ff 02 00 fe 01 03 ff ff9c
0000 0000 0002 0025 0022 003e 0061 005e 007a
// reload_w: pixels kept from mix_sign, center tap 2, bias 5
72656c6f61645f77 0
00 01 04 09 10 19 24 31 0a 0b 0e 13 1a 23 2e 3b 14 15 18 1d 24 2d 38 45 1e 1f 22 27 2e 37 42 4f
28 29 2c 31 38 41 4c 59 32 33 36 3b 42 4b 56 63 3c 3d 40 45 4c 55 60 6d 46 47 4a 4f 56 5f 6a 77
00 00 00 00 02 00 00 00 00 0005
0035 004d 0075 005d 0075 009d 0085 009d 00c5
// neg_bias: ramp image, unit kernel, bias -32768
6e65675f62696173 1
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
01 01 01 01 01 01 01 01 01 8000
0000 0000 0000 0000 0000 0000 0000 0000 0000
// clip_max: full-scale pixels and weights
636c69705f6d6178 1
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
7f 7f 7f 7f 7f 7f 7f 7f 7f 0000
ffff ffff ffff ffff ffff ffff ffff ffff ffff
// big_sums: pixel 30*c + 5*r, weights 127, bias -32768, partly clipped
6269675f73756d73 1
00 1e 3c 5a 78 96 b4 d2 05 23 41 5f 7d 9b b9 d7 0a 28 46 64 82 a0 be dc 0f 2d 4b 69 87 a5 c3 e1
14 32 50 6e 8c aa c8 e6 19 37 55 73 91 af cd eb 1e 3c 5a 78 96 b4 d2 f0 23 41 5f 7d 9b b9 d7 f5
7f 7f 7f 7f 7f 7f 7f 7f 7f 8000
b88a ffff ffff e530 ffff ffff ffff ffff ffff

// File: tb/cnn_checker.sv
`timescale 1ns/1ps

module cnn_checker (
	input logic                 clk,
	input logic                 rst,
	input logic                 start,
	input logic                 interrupt_signal,
	input cnn_pkg::bus_word_t   awaddr,
	input logic                 awvalid,
	input cnn_pkg::bus_word_t   wdata,
	input logic                 wvalid,
	input logic                 save_enable,
	input cnn_pkg::coord_t      save_row,
	input cnn_pkg::coord_t      save_col,
	input cnn_pkg::conv_state_t conv_state
);

	logic irq_clear;

	assign irq_clear = awvalid && wvalid && (awaddr == cnn_pkg::INTERRUPT_ADDR)
		&& (wdata == '0);

	////////////////////
	// start
	start_one_cycle: assert property (@(posedge clk) disable iff (rst)
		start |=> !start)
		else $error("start pulse held for more than one cycle");

	////////////////////
	// interrupt and saves
	irq_falls_on_clear: assert property (@(posedge clk) disable iff (rst)
		$fell(interrupt_signal) |-> $past(irq_clear))
		else $error("interrupt fell without a zero write to the interrupt address");

	// pooling only ends after the convolution is back in IDLE
	irq_rises_when_idle: assert property (@(posedge clk) disable iff (rst)
		$rose(interrupt_signal) |-> conv_state == cnn_pkg::IDLE)
		else $error("interrupt rose while the convolution was still running");

	save_in_range: assert property (@(posedge clk) disable iff (rst)
		save_enable |-> (save_row < cnn_pkg::CONV_SIZE) && (save_col < cnn_pkg::CONV_SIZE))
		else $error("save position outside the convolution output");

endmodule

bind cnn cnn_checker cnn_checker_i (
	.clk              (clk),
	.rst              (rst),
	.start            (start),
	.interrupt_signal (interrupt_signal),
	.awaddr           (awaddr),
	.awvalid          (awvalid),
	.wdata            (wdata),
	.wvalid           (wvalid),
	.save_enable      (save_bus.save_enable),
	.save_row         (save_bus.row),
	.save_col         (save_bus.col),
	.conv_state       (conv_layer_i.state)
);

// File: tb/tb_cnn.sv
`timescale 1ns/1ps

module tb_cnn;

	localparam int NUM_TESTS = 5;
	// name, pixel flag, 64 pixels, 9 weights, bias, 9 results
	localparam int CASE_WORDS = 85;
	localparam int PIXEL_OFS = 2;
	localparam int WEIGHT_OFS = 66;
	localparam int BIAS_OFS = 75;
	localparam int EXPECT_OFS = 76;
	localparam int WAIT_LIMIT = 1000;
	localparam int CYCLE_LIMIT = NUM_TESTS * 1000 + 200;

	logic clk;
	logic rst;
	cnn_pkg::bus_word_t araddr;
	logic arvalid;
	cnn_pkg::bus_word_t awaddr;
	logic awvalid;
	cnn_pkg::bus_word_t wdata;
	logic wvalid;
	cnn_pkg::bus_word_t rdata;
	logic interrupt_signal;

	logic [63:0] cases [NUM_TESTS * CASE_WORDS];
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	int cycles;

	cnn cnn_i (
		.clk              (clk),
		.rst              (rst),
		.araddr           (araddr),
		.arvalid          (arvalid),
		.awaddr           (awaddr),
		.awvalid          (awvalid),
		.wdata            (wdata),
		.wvalid           (wvalid),
		.rdata            (rdata),
		.interrupt_signal (interrupt_signal)
	);

	always #4 clk = ~clk;

	// hard stop for a stuck run
	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not end within %0d clock cycles", CYCLE_LIMIT);
		$display("Finished with errors");
		$finish;
	end

	////////////////////
	// bus helpers start and end on a falling edge
	task automatic check_value(input string what, input cnn_pkg::bus_word_t expected,
		input cnn_pkg::bus_word_t actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s: expected %h, actual %h", what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic bus_write(input cnn_pkg::bus_word_t addr, input cnn_pkg::bus_word_t data);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
	endtask

	// rdata is registered, so it is valid at the next falling edge
	task automatic bus_read(input cnn_pkg::bus_word_t addr, output cnn_pkg::bus_word_t data);
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		data = rdata;
		arvalid = 1'b0;
	endtask

	task automatic wait_interrupt(input string name, output logic seen);
		int waited;
		waited = 0;
		while (!interrupt_signal && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		seen = interrupt_signal;
		if (!seen)
		begin
			$display("test %s: interrupt_signal did not rise within %0d cycles", name, WAIT_LIMIT);
			errors++;
			test_errors++;
		end
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (test_errors == 0)
			$display("test %s passed", name);
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	////////////////////
	// tests
	task automatic check_reset_state();
		cnn_pkg::bus_word_t value;
		check_value("reset interrupt", '0, {31'h0, interrupt_signal});
		for (int i = 0; i < cnn_pkg::NUM_RESULTS; i++)
		begin
			bus_read(cnn_pkg::RESULT_BASE + cnn_pkg::bus_word_t'(i), value);
			check_value($sformatf("reset result %0d", i), '0, value);
		end
		close_test("reset");
	endtask

	task automatic run_case(input int t);
		int base;
		string name;
		logic seen;
		cnn_pkg::bus_word_t value;
		base = t * CASE_WORDS;
		name = $sformatf("%s", cases[base]);
		// flag zero keeps the pixels of the previous test
		if (cases[base + 1] != 0)
		begin
			for (int p = 0; p < cnn_pkg::IMG_SIZE * cnn_pkg::IMG_SIZE; p++)
				bus_write(cnn_pkg::PIXEL_BASE + cnn_pkg::bus_word_t'(p),
					{24'h0, cases[base + PIXEL_OFS + p][7:0]});
		end
		for (int k = 0; k < cnn_pkg::KERNEL_SIZE * cnn_pkg::KERNEL_SIZE; k++)
			bus_write(cnn_pkg::WEIGHT_BASE + cnn_pkg::bus_word_t'(k),
				{24'h0, cases[base + WEIGHT_OFS + k][7:0]});
		bus_write(cnn_pkg::BIAS_BASE, {24'h0, cases[base + BIAS_OFS][7:0]});
		bus_write(cnn_pkg::BIAS_BASE + 32'h1, {24'h0, cases[base + BIAS_OFS][15:8]});
		bus_write(cnn_pkg::IMAGE_SET_ADDR, 32'h1);
		wait_interrupt(name, seen);
		if (seen)
		begin
			for (int i = 0; i < cnn_pkg::NUM_RESULTS; i++)
			begin
				bus_read(cnn_pkg::RESULT_BASE + cnn_pkg::bus_word_t'(i), value);
				check_value($sformatf("%s result %0d", name, i),
					{16'h0, cases[base + EXPECT_OFS + i][15:0]}, value);
			end
			check_value({name, " interrupt held"}, 32'h1, {31'h0, interrupt_signal});
			// only a zero write clears it
			bus_write(cnn_pkg::INTERRUPT_ADDR, 32'h1);
			check_value({name, " interrupt after nonzero write"}, 32'h1,
				{31'h0, interrupt_signal});
			bus_write(cnn_pkg::INTERRUPT_ADDR, 32'h0);
			check_value({name, " interrupt after clear"}, '0, {31'h0, interrupt_signal});
		end
		close_test(name);
	endtask

	task automatic check_outside_reads();
		cnn_pkg::bus_word_t value;
		bus_read(32'h6000_0000, value);
		check_value("outside 6000_0000", '0, value);
		bus_read(cnn_pkg::PIXEL_BASE, value);
		check_value("outside pixel region", '0, value);
		// inside the region but past the last result
		bus_read(cnn_pkg::RESULT_BASE + 32'h9, value);
		check_value("outside result 9", '0, value);
		close_test("outside");
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		$readmemh("tb/cnn_cases.txt", cases);
		repeat (4) @(negedge clk);
		rst = 1'b0;
		if ($isunknown(cases[0]))
		begin
			$display("error: the case file tb/cnn_cases.txt could not be read");
			errors++;
		end
		else
		begin
			check_reset_state();
			for (int t = 0; t < NUM_TESTS; t++)
				run_case(t);
			check_outside_reads();
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
